// ==== hdl/regfile_pkg.sv ====
`default_nettype none

package regfile_pkg;

  // Architectural widths.
  typedef logic [31:0] xlen_t;      // Data word, pc and CSR value.
  typedef logic [4:0]  reg_idx_t;   // Wide enough for RV32I. RV32E uses 16 of 32.
  typedef logic [11:0] csr_addr_t;

  // Machine-mode CSR addresses.
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;

  // Field positions inside mstatus.
  localparam int MSTATUS_MIE    = 3;
  localparam int MSTATUS_MPIE   = 7;
  localparam int MSTATUS_MPP_LO = 11;
  localparam int MSTATUS_MPP_HI = 12;

  localparam xlen_t MSTATUS_RESET = 32'h0000_1800;  // MPP holds machine mode.
  localparam xlen_t CAUSE_ECALL_M = 32'd11;         // Environment call from M-mode.

  // Source operands requested by decode.
  typedef struct packed {
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    csr_addr_t csr_addr;
  } read_req_t;

  // Operand values returned to decode.
  typedef struct packed {
    xlen_t src1;
    xlen_t src2;
    xlen_t csr_data;
  } read_rsp_t;

  // One retiring instruction from writeback.
  typedef struct packed {
    xlen_t     pc;         // Saved into mepc on ecall.
    reg_idx_t  rd;
    logic      gpr_wen;
    xlen_t     gpr_wdata;
    logic      csr_wen;
    csr_addr_t csr_waddr;
    xlen_t     csr_wdata;
    logic      ecall;
    logic      mret;
  } wb_req_t;

endpackage

`default_nettype wire

// ==== hdl/gpr_bank.sv ====
`default_nettype none

module gpr_bank #(
  parameter int NUM_GPR = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  regfile_pkg::reg_idx_t rs1,
  input  regfile_pkg::reg_idx_t rs2,
  input  regfile_pkg::reg_idx_t rd,
  input  logic                  wen,
  input  regfile_pkg::xlen_t    wdata,
  output regfile_pkg::xlen_t    src1,
  output regfile_pkg::xlen_t    src2
);
  import regfile_pkg::*;

  // Register zero has no storage.
  xlen_t              gpr_q [1:NUM_GPR-1];
  logic               rd_nonzero;
  logic               rd_in_range;
  logic               wr_ok;
  logic [NUM_GPR-1:1] wr_sel;

  assign rd_nonzero  = (rd != '0);
  assign rd_in_range = (32'(rd) < NUM_GPR);
  assign wr_ok       = wen && rd_nonzero && rd_in_range;

  // One-hot select of the register being written.
  always_comb begin
    for (int i = 1; i < NUM_GPR; i++) begin
      wr_sel[i] = wr_ok && (rd == reg_idx_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_GPR; i++) begin
        gpr_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NUM_GPR; i++) begin
        if (wr_sel[i]) begin
          gpr_q[i] <= wdata;
        end
      end
    end
  end

  // x0 and indices past the bank read as zero.
  function automatic xlen_t read_gpr(input reg_idx_t idx);
    xlen_t val;
    val = '0;
    if ((idx != '0) && (32'(idx) < NUM_GPR)) begin
      val = gpr_q[idx];
    end
    return val;
  endfunction

  // No bypass. A same-cycle write shows up next cycle.
  always_comb begin
    src1 = read_gpr(rs1);
    src2 = read_gpr(rs2);
  end

endmodule

`default_nettype wire

// ==== hdl/csr_unit.sv ====
`default_nettype none

module csr_unit #(
  parameter regfile_pkg::xlen_t VENDOR_ID = 32'h7973_7978,
  parameter regfile_pkg::xlen_t ARCH_ID   = 32'h017D_C685
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_valid,
  input  regfile_pkg::wb_req_t   wb,
  input  regfile_pkg::csr_addr_t csr_addr,
  output regfile_pkg::xlen_t     csr_data
);
  import regfile_pkg::*;

  xlen_t mstatus_q;
  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;

  logic  trap_entry;
  logic  trap_return;
  logic  csr_write;
  logic  wr_mstatus;
  logic  wr_mtvec;
  logic  wr_mepc;
  logic  wr_mcause;

  xlen_t mstatus_ret;
  xlen_t mstatus_d;
  xlen_t mepc_d;
  xlen_t mcause_d;

  // Priority is ecall, then mret, then a plain CSR write.
  assign trap_entry  = wb_valid && wb.ecall;
  assign trap_return = wb_valid && wb.mret && !wb.ecall;
  assign csr_write   = wb_valid && wb.csr_wen && !wb.ecall && !wb.mret;

  // Write address decode.
  always_comb begin
    wr_mstatus = 1'b0;
    wr_mtvec   = 1'b0;
    wr_mepc    = 1'b0;
    wr_mcause  = 1'b0;
    if (csr_write) begin
      case (wb.csr_waddr)
        CSR_MSTATUS: wr_mstatus = 1'b1;
        CSR_MTVEC:   wr_mtvec   = 1'b1;
        CSR_MEPC:    wr_mepc    = 1'b1;
        CSR_MCAUSE:  wr_mcause  = 1'b1;
        default:     ;  // mvendorid, marchid and unknown addresses drop the write
      endcase
    end
  end

  // mret restores MIE from MPIE and returns MPP to user.
  always_comb begin
    mstatus_ret = mstatus_q;
    mstatus_ret[MSTATUS_MIE] = mstatus_q[MSTATUS_MPIE];
    mstatus_ret[MSTATUS_MPIE] = 1'b1;
    mstatus_ret[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = 2'b00;
  end

  always_comb begin
    if (trap_entry) begin
      mstatus_d = MSTATUS_RESET;
    end else if (trap_return) begin
      mstatus_d = mstatus_ret;
    end else if (wr_mstatus) begin
      mstatus_d = wb.csr_wdata;
    end else begin
      mstatus_d = mstatus_q;
    end
  end

  always_comb begin
    if (trap_entry) begin
      mepc_d = wb.pc;  // Pc of the ecall itself.
    end else if (wr_mepc) begin
      mepc_d = wb.csr_wdata;
    end else begin
      mepc_d = mepc_q;
    end
  end

  always_comb begin
    if (trap_entry) begin
      mcause_d = CAUSE_ECALL_M;
    end else if (wr_mcause) begin
      mcause_d = wb.csr_wdata;
    end else begin
      mcause_d = mcause_q;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mstatus_q <= MSTATUS_RESET;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
      if (wr_mtvec) begin
        mtvec_q <= wb.csr_wdata;
      end
    end
  end

  // Read mux.
  always_comb begin
    case (csr_addr)
      CSR_MSTATUS:   csr_data = mstatus_q;
      CSR_MTVEC:     csr_data = mtvec_q;
      CSR_MEPC:      csr_data = mepc_q;
      CSR_MCAUSE:    csr_data = mcause_q;
      CSR_MVENDORID: csr_data = VENDOR_ID;
      CSR_MARCHID:   csr_data = ARCH_ID;
      default:       csr_data = '0;  // Unimplemented CSR.
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/arch_state_top.sv ====
`default_nettype none

module arch_state_top #(
  parameter int                 NUM_GPR   = 16,            // 16 for RV32E, 32 for RV32I.
  parameter regfile_pkg::xlen_t VENDOR_ID = 32'h7973_7978,
  parameter regfile_pkg::xlen_t ARCH_ID   = 32'h017D_C685
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  regfile_pkg::read_req_t rd_req,
  output regfile_pkg::read_rsp_t rd_rsp,
  input  logic                   wb_valid,
  input  regfile_pkg::wb_req_t   wb
);
  import regfile_pkg::*;

  logic  gpr_wen;
  xlen_t gpr_src1;
  xlen_t gpr_src2;
  xlen_t csr_rdata;

  // Single register write enable for the bank.
  assign gpr_wen = wb_valid && wb.gpr_wen;

  gpr_bank #(
    .NUM_GPR (NUM_GPR)
  ) u_gpr_bank (
    .clk   (clk),
    .rst_n (rst_n),
    .rs1   (rd_req.rs1),
    .rs2   (rd_req.rs2),
    .rd    (wb.rd),
    .wen   (gpr_wen),
    .wdata (wb.gpr_wdata),
    .src1  (gpr_src1),
    .src2  (gpr_src2)
  );

  csr_unit #(
    .VENDOR_ID (VENDOR_ID),
    .ARCH_ID   (ARCH_ID)
  ) u_csr_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_valid (wb_valid),
    .wb       (wb),
    .csr_addr (rd_req.csr_addr),
    .csr_data (csr_rdata)
  );

  // Join the read results for decode.
  always_comb begin
    rd_rsp.src1     = gpr_src1;
    rd_rsp.src2     = gpr_src2;
    rd_rsp.csr_data = csr_rdata;
  end

endmodule

`default_nettype wire

// ==== verification/arch_state_chk.sv ====
`default_nettype none

module arch_state_chk (
  input logic                   clk,
  input logic                   rst_n,
  input regfile_pkg::read_req_t rd_req,
  input regfile_pkg::read_rsp_t rd_rsp,
  input logic                   wb_valid,
  input regfile_pkg::wb_req_t   wb
);
  import regfile_pkg::*;

  int fail_count = 0;

  // x0 reads zero on both ports.
  src1_zero_a: assert property (@(posedge clk) (rd_req.rs1 == '0) |-> (rd_rsp.src1 == '0))
    else begin
      $error("src1 is not zero while rs1 is zero");
      fail_count++;
    end
  src2_zero_a: assert property (@(posedge clk) (rd_req.rs2 == '0) |-> (rd_rsp.src2 == '0))
    else begin
      $error("src2 is not zero while rs2 is zero");
      fail_count++;
    end

  ecall_mepc_a: assert property (@(posedge clk) (rst_n && wb_valid && wb.ecall) |=>
                  (rd_req.csr_addr != CSR_MEPC) || (rd_rsp.csr_data == $past(wb.pc)))
    else begin
      $error("mepc does not hold the pc of the ecall");
      fail_count++;
    end

  // First cycle out of reset.
  mstatus_reset_a: assert property (@(posedge clk) $rose(rst_n) |->
                     (rd_req.csr_addr != CSR_MSTATUS) || (rd_rsp.csr_data == MSTATUS_RESET))
    else begin
      $error("mstatus is not at its reset value after reset");
      fail_count++;
    end

endmodule

bind arch_state_top arch_state_chk u_arch_state_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .rd_req   (rd_req),
  .rd_rsp   (rd_rsp),
  .wb_valid (wb_valid),
  .wb       (wb)
);

`default_nettype wire

// ==== verification/arch_state_tb.sv ====
`default_nettype none

module arch_state_tb;
  import regfile_pkg::*;

  localparam int    NUM_GPR         = 16;
  localparam xlen_t VENDOR_ID       = 32'h7973_7978;
  localparam xlen_t ARCH_ID         = 32'h017D_C685;
  localparam int    CLK_PERIOD      = 40;
  localparam int    NUM_GPR_WRITES  = 200;
  localparam int    NUM_CSR_WRITES  = 60;
  localparam int    NUM_TRAP_ROUNDS = 10;
  localparam int    TEST_CYCLES     = 4 + 32 + NUM_GPR_WRITES + 3 + 8 + NUM_CSR_WRITES
                                      + 7 * NUM_TRAP_ROUNDS;
  // Entry 6 is an address with no CSR behind it.
  localparam logic [6:0][11:0] CSR_ADDRS = {12'h7C0, CSR_MARCHID, CSR_MVENDORID, CSR_MCAUSE,
                                            CSR_MEPC, CSR_MTVEC, CSR_MSTATUS};

  logic        clk = 1'b0;
  logic        rst_n;
  logic        wb_valid;
  read_req_t   rd_req;
  read_rsp_t   rd_rsp;
  wb_req_t     wb;
  xlen_t       gpr_m [32];  // x0 and entries past NUM_GPR are never written.
  xlen_t       mstatus_m;
  xlen_t       mtvec_m;
  xlen_t       mepc_m;
  xlen_t       mcause_m;
  int          error_count = 0;
  int          check_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  arch_state_top #(.NUM_GPR(NUM_GPR), .VENDOR_ID(VENDOR_ID), .ARCH_ID(ARCH_ID)) UUT (.*);

  function automatic reg_idx_t rand_idx(input int max);
    return reg_idx_t'($urandom_range(0, max));
  endfunction

  function automatic csr_addr_t rand_csr();
    return CSR_ADDRS[3'($urandom_range(0, 6))];
  endfunction

  function automatic xlen_t expected_csr(input csr_addr_t addr);
    case (addr)
      CSR_MSTATUS:   return mstatus_m;
      CSR_MTVEC:     return mtvec_m;
      CSR_MEPC:      return mepc_m;
      CSR_MCAUSE:    return mcause_m;
      CSR_MVENDORID: return VENDOR_ID;
      CSR_MARCHID:   return ARCH_ID;
      default:       return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
    check_count++;
    assert (act === exp) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  // One retirement at a rising edge.
  task automatic update_model();
    xlen_t ret;
    if (wb_valid) begin
      if (wb.gpr_wen && (wb.rd != '0) && (int'(wb.rd) < NUM_GPR)) begin
        gpr_m[wb.rd] = wb.gpr_wdata;
      end
      if (wb.ecall) begin
        mepc_m    = wb.pc;
        mcause_m  = CAUSE_ECALL_M;
        mstatus_m = MSTATUS_RESET;
      end else if (wb.mret) begin
        ret        = mstatus_m;
        ret[3]     = mstatus_m[7];  // MIE from MPIE.
        ret[7]     = 1'b1;
        ret[12:11] = 2'b00;
        mstatus_m  = ret;
      end else if (wb.csr_wen) begin
        case (wb.csr_waddr)
          CSR_MSTATUS: mstatus_m = wb.csr_wdata;
          CSR_MTVEC:   mtvec_m   = wb.csr_wdata;
          CSR_MEPC:    mepc_m    = wb.csr_wdata;
          CSR_MCAUSE:  mcause_m  = wb.csr_wdata;
          default:     ;
        endcase
      end
    end
  endtask

  task automatic set_wb(input logic valid, input logic gpr_wen, input reg_idx_t rd,
                        input logic csr_wen, input csr_addr_t waddr, input logic ecall,
                        input logic mret);
    wb_valid     = valid;
    wb.pc        = $urandom() & 32'hFFFF_FFFC;
    wb.rd        = rd;
    wb.gpr_wen   = gpr_wen;
    wb.gpr_wdata = $urandom();
    wb.csr_wen   = csr_wen;
    wb.csr_waddr = waddr;
    wb.csr_wdata = $urandom();
    wb.ecall     = ecall;
    wb.mret      = mret;
  endtask

  task automatic clear_wb();
    wb_valid = 1'b0;
    wb       = '0;
  endtask

  // Reads are checked at the falling edge. The model follows the rising edge.
  task automatic run_cycle(input string name, input reg_idx_t rs1, input reg_idx_t rs2,
                           input csr_addr_t caddr);
    rd_req.rs1      = rs1;
    rd_req.rs2      = rs2;
    rd_req.csr_addr = caddr;
    @(negedge clk);
    check_value({name, " src1"}, gpr_m[rs1], rd_rsp.src1);
    check_value({name, " src2"}, gpr_m[rs2], rd_rsp.src2);
    check_value({name, " csr_data"}, expected_csr(caddr), rd_rsp.csr_data);
    @(posedge clk);
    update_model();
    #5;
  endtask

  initial begin
    void'($urandom(32'h95bf));
    rst_n    = 1'b0;
    rd_req   = '0;
    clear_wb();
    for (int i = 0; i < 32; i++) begin
      gpr_m[i] = '0;
    end
    mstatus_m = MSTATUS_RESET;
    mtvec_m   = '0;
    mepc_m    = '0;
    mcause_m  = '0;
    repeat (4) @(posedge clk);
    #5;
    rst_n = 1'b1;

    for (int i = 0; i < 32; i++) begin
      run_cycle("reset_values", reg_idx_t'(i), reg_idx_t'(31 - i), CSR_ADDRS[3'(i % 7)]);
    end

    for (int n = 0; n < NUM_GPR_WRITES; n++) begin
      set_wb($urandom_range(0, 7) != 0, 1'b1, rand_idx(17), 1'b0, '0, 1'b0, 1'b0);
      run_cycle("gpr_write", rand_idx(15), rand_idx(31), rand_csr());
    end
    set_wb(1'b1, 1'b1, 5'd0, 1'b0, '0, 1'b0, 1'b0);
    run_cycle("x0_write", 5'd0, 5'd5, CSR_MSTATUS);
    set_wb(1'b0, 1'b1, 5'd5, 1'b0, '0, 1'b0, 1'b0);  // Strobe low.
    run_cycle("write_without_valid", 5'd0, 5'd5, CSR_MSTATUS);
    clear_wb();
    run_cycle("after_write_without_valid", 5'd5, 5'd0, CSR_MSTATUS);

    for (int i = 1; i <= 4; i++) begin
      set_wb(1'b1, 1'b1, reg_idx_t'(3 * i), 1'b0, '0, 1'b0, 1'b0);
      run_cycle("read_during_write", reg_idx_t'(3 * i), reg_idx_t'(3 * i), CSR_MEPC);
      clear_wb();
      run_cycle("read_after_write", reg_idx_t'(3 * i), reg_idx_t'(3 * i), CSR_MEPC);
    end

    for (int n = 0; n < NUM_CSR_WRITES; n++) begin
      set_wb(1'b1, 1'b0, '0, 1'b1, rand_csr(), 1'b0, 1'b0);
      run_cycle("csr_write", rand_idx(15), rand_idx(15), rand_csr());
    end

    for (int n = 0; n < NUM_TRAP_ROUNDS; n++) begin
      set_wb(1'b1, 1'b0, '0, n[0], CSR_MEPC, 1'b1, 1'b0);  // Odd rounds race an mepc write.
      run_cycle("ecall", 5'd0, 5'd0, CSR_MEPC);
      clear_wb();
      run_cycle("ecall_mepc", 5'd0, 5'd0, CSR_MEPC);
      run_cycle("ecall_mcause", 5'd0, 5'd0, CSR_MCAUSE);
      run_cycle("ecall_mstatus", 5'd0, 5'd0, CSR_MSTATUS);
      set_wb(1'b1, 1'b0, '0, 1'b1, CSR_MSTATUS, 1'b0, 1'b0);
      run_cycle("mstatus_write", 5'd0, 5'd0, CSR_MSTATUS);
      set_wb(1'b1, 1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
      run_cycle("mret", 5'd0, 5'd0, CSR_MSTATUS);
      clear_wb();
      run_cycle("mret_mstatus", 5'd0, 5'd0, CSR_MSTATUS);
    end

    $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count, error_count,
             UUT.u_arch_state_chk.fail_count);
    if ((error_count == 0) && (UUT.u_arch_state_chk.fail_count == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #((TEST_CYCLES + 100) * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", TEST_CYCLES + 100);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/regfile_pkg.sv
hdl/gpr_bank.sv
hdl/csr_unit.sv
hdl/arch_state_top.sv
verification/arch_state_chk.sv
verification/arch_state_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the arch_state testbench with Verilator.
set -u
cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

verilator --binary --assert --top-module arch_state_tb -f compile.f \
  --Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
